// File: ldst_subsys.f
ldst_pkg.sv
byte_selector.sv
ldst_issue.sv
data_ram.sv
load_unit.sv
ldst_subsys.sv
ldst_properties.sv
tb_ldst_subsys.sv

// File: Makefile
# Verilator flow for the load/store subsystem

VERILATOR ?= verilator
TOP       ?= tb_ldst_subsys
FILELIST  ?= ldst_subsys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_ldst_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ldst_subsys;

  import ldst_pkg::*;

  // Memory geometry for the default top level
  localparam int unsigned ADDR_W  = 8;
  localparam int unsigned N_WORDS = 2 ** (ADDR_W - OFF_W);
  localparam int unsigned N_BYTES = 2 ** ADDR_W;
  localparam int unsigned N_RAND  = 300;
  localparam int unsigned SEED    = 18470;
  // Upper bound on requests over all phases
  localparam int unsigned N_REQ = 2 * N_WORDS + 4 * 28 + 2 * 16 + 2 * 16 + 2 * N_RAND + 4;
  // 40 ns per request, plus reset and idle cycles
  localparam int unsigned TIMEOUT_NS = N_REQ * 40 + 40 * 20 + 2000;

  logic      clk = 1'b0;
  logic      arst_n;
  logic      req_valid;
  ldst_req_t req;
  logic      rsp_valid;
  ld_rsp_t   rsp;
  logic      misalign;

  // Byte-wide shadow of the data memory
  logic [BYTE_LEN-1:0] shadow [N_BYTES];
  // Expected load data, in issue order
  logic [XLEN-1:0]     exp_q [$];
  // Expected strobes, one and two cycles out
  logic                mis_exp;
  logic [1:0]          ld_exp;

  always #10 clk = ~clk;

  ldst_subsys #(
    .ADDR_W (ADDR_W)
  ) i_dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .misalign_o  (misalign)
  );

  // ------------------------------
  // Reference model
  // ------------------------------
  // Bytes moved by one access of the given width
  function automatic int unsigned access_bytes(input ldst_width_t w);
    case (w)
      LS_BYTE, LS_BYTE_U:         return 1;
      LS_HALFWORD, LS_HALFWORD_U: return 2;
      LS_WORD, LS_WORD_U:         return 4;
      default:                    return 8;
    endcase
  endfunction

  // Natural alignment, address a multiple of the access size
  function automatic logic is_misaligned(input ldst_width_t w, input logic [ADDR_W-1:0] a);
    return (a % access_bytes(w)) != 0;
  endfunction

  // Load value from shadow bytes, little endian
  function automatic logic [XLEN-1:0] expected_load(input ldst_width_t w,
                                                    input logic [ADDR_W-1:0] a);
    logic [XLEN-1:0] raw;
    logic [XLEN-1:0] top;
    int unsigned     n;
    raw = '0;
    n   = access_bytes(w);
    for (int unsigned i = 0; i < n; i++) begin
      raw = raw | (XLEN'(shadow[ADDR_W'(a + i)]) << (i * BYTE_LEN));
    end
    // Signed types copy their top bit upward
    top = raw >> (n * BYTE_LEN - 1);
    if ((w == LS_BYTE || w == LS_HALFWORD || w == LS_WORD) && top[0]) begin
      raw = raw | ({XLEN{1'b1}} << (n * BYTE_LEN));
    end
    return raw;
  endfunction

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  // One request; shadow and queue follow at issue
  task automatic send(input logic st, input ldst_width_t w, input logic [ADDR_W-1:0] a,
                      input logic [XLEN-1:0] d);
    ldst_req_t   r;
    int unsigned n;
    r.is_store = st;
    r.width    = w;
    r.addr     = REQ_ADDR_W'(a);
    r.wdata    = d;
    n          = access_bytes(w);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
    if (!is_misaligned(w, a)) begin
      if (st) begin
        for (int unsigned i = 0; i < n; i++) begin
          shadow[ADDR_W'(a + i)] = 8'(d >> (i * BYTE_LEN));
        end
      end else begin
        exp_q.push_back(expected_load(w, a));
      end
    end
  endtask

  task automatic idle(input int unsigned cycles);
    repeat (cycles) begin
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  // Wait for all queued loads to return
  task automatic drain();
    idle(1);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check(input string what, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // ------------------------------
  // Response checker
  // ------------------------------
  // Negedge sampling, outputs settled by then
  always @(negedge clk) begin : compare
    if (!arst_n) begin
      check("rsp_valid_o in reset", XLEN'(rsp_valid), '0);
      check("misalign_o in reset", XLEN'(misalign), '0);
      mis_exp = 1'b0;
      ld_exp  = 2'b00;
      exp_q.delete();
    end else begin
      check("misalign_o", XLEN'(misalign), XLEN'(mis_exp));
      check("rsp_valid_o", XLEN'(rsp_valid), XLEN'(ld_exp[1]));
      if (rsp_valid) begin
        check("load data", rsp.data, exp_q.pop_front());
      end
      // Request visible now, sampled at the next edge
      mis_exp = req_valid && is_misaligned(req.width, req.addr[ADDR_W-1:0]);
      ld_exp  = {ld_exp[0],
                 req_valid && !req.is_store && !is_misaligned(req.width, req.addr[ADDR_W-1:0])};
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("TESTBENCH FAILED");
    $fatal(1, "Timeout");
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : stimulus
    ldst_width_t       w;
    logic [ADDR_W-1:0] a;
    logic              st;
    void'($urandom(SEED));
    arst_n    <= 1'b0;
    req_valid <= 1'b0;
    req       <= '0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    idle(2);

    // Fill every word, read each back
    for (int unsigned i = 0; i < N_WORDS; i++) begin
      send(1'b1, LS_DOUBLEWORD, ADDR_W'(i * 8), {$urandom, $urandom});
    end
    for (int unsigned i = 0; i < N_WORDS; i++) begin
      send(1'b0, LS_DOUBLEWORD, ADDR_W'(i * 8), '0);
    end
    drain();

    // Every signed and unsigned sub-word load, aligned offsets only
    for (int unsigned i = 0; i < 4 * NUM_LANES; i++) begin
      for (int unsigned k = 0; k < 6; k++) begin
        w = ldst_width_t'(3'(k));
        if (!is_misaligned(w, ADDR_W'(i))) begin
          send(1'b0, w, ADDR_W'(i), '0);
        end
      end
    end
    drain();

    // Partial stores, merged word read right after
    for (int unsigned i = 0; i < 16; i++) begin
      w = ldst_width_t'(3'(2 * $urandom_range(2)));
      a = ADDR_W'($urandom_range(N_BYTES - 1)) & ~ADDR_W'(access_bytes(w) - 1);
      send(1'b1, w, a, {$urandom, $urandom});
      send(1'b0, LS_DOUBLEWORD, {a[ADDR_W-1:OFF_W], 3'b000}, '0);
    end
    drain();

    // Misaligned stores and loads, memory must stay put
    for (int unsigned i = 0; i < 16; i++) begin
      w = ldst_width_t'(3'(2 + $urandom_range(4)));
      a = ADDR_W'($urandom_range(N_BYTES - 1));
      if (!is_misaligned(w, a)) begin
        a[0] = 1'b1;
      end
      send(i[0], w, a, {$urandom, $urandom});
      send(1'b0, LS_DOUBLEWORD, {a[ADDR_W-1:OFF_W], 3'b000}, '0);
    end
    drain();

    // Random back-to-back traffic
    for (int unsigned i = 0; i < N_RAND; i++) begin
      w  = ldst_width_t'(3'($urandom_range(6)));
      a  = ADDR_W'($urandom_range(N_BYTES - 1)) & ~ADDR_W'(access_bytes(w) - 1);
      st = 1'($urandom_range(1));
      send(st, w, a, {$urandom, $urandom});
      // Sometimes a load of the same word at once
      if (st && $urandom_range(3) == 0) begin
        send(1'b0, LS_DOUBLEWORD, {a[ADDR_W-1:OFF_W], 3'b000}, '0);
      end
    end
    drain();

    // Reset with a load and a misaligned request in flight
    send(1'b0, LS_WORD, ADDR_W'(8'h10), '0);
    send(1'b0, LS_WORD, ADDR_W'(8'h12), '0);
    @(posedge clk);
    req_valid <= 1'b0;
    arst_n    <= 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    // Quiet outputs until the next request
    idle(6);
    send(1'b0, LS_DOUBLEWORD, ADDR_W'(8'h18), '0);
    drain();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: ldst_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_properties (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                req_valid_i,
  input ldst_pkg::ldst_req_t req_i,
  input logic                rsp_valid_i,
  input logic                misalign_i
);

  import ldst_pkg::*;

  logic [OFF_W-1:0] mask;
  logic             aligned_load;

  // Offset bits that must be clear per width
  always_comb begin : mask_decode
    case (req_i.width)
      LS_BYTE, LS_BYTE_U:         mask = 3'b000;
      LS_HALFWORD, LS_HALFWORD_U: mask = 3'b001;
      LS_WORD, LS_WORD_U:         mask = 3'b011;
      default:                    mask = 3'b111;
    endcase
  end

  assign aligned_load = req_valid_i && !req_i.is_store &&
                        ((req_i.addr[OFF_W-1:0] & mask) == '0);

  // ------------------------------
  // Timing and exclusion
  // ------------------------------
  // Load response two edges after sampling
  load_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aligned_load |-> ##2 rsp_valid_i)
    else $error("Aligned load without response two cycles later");

  // Error pulse and response of one request never both
  misalign_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    misalign_i |=> !rsp_valid_i)
    else $error("Response for a request flagged misaligned");

  // Quiet outputs while in reset
  reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> (!rsp_valid_i && !misalign_i))
    else $error("Output strobe high during reset");

endmodule

bind ldst_subsys ldst_properties i_ldst_properties (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_valid_i (req_valid_i),
  .req_i       (req_i),
  .rsp_valid_i (rsp_valid_o),
  .misalign_i  (misalign_o)
);

`default_nettype wire

// File: ldst_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_subsys #(
  parameter int unsigned ADDR_W = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_valid_i,
  input  ldst_pkg::ldst_req_t req_i,
  output logic                rsp_valid_o,
  output ldst_pkg::ld_rsp_t   rsp_o,
  output logic                misalign_o
);

  import ldst_pkg::*;

  // Issue stage to memory
  logic     cmd_valid;
  ram_cmd_t cmd;

  // Issue stage to load unit
  logic    ld_issue;
  ld_tag_t tag;

  // Memory read data
  logic [XLEN-1:0] rdata;

  // ----------------------------
  // Issue, alignment, lane shift
  // ----------------------------
  ldst_issue #(
    .ADDR_W (ADDR_W)
  ) i_ldst_issue (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .ld_issue_o  (ld_issue),
    .tag_o       (tag),
    .misalign_o  (misalign_o)
  );

  // Data memory
  data_ram #(
    .ADDR_W (ADDR_W)
  ) i_data_ram (
    .clk_i       (clk_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .rdata_o     (rdata)
  );

  // Load response path
  load_unit i_load_unit (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ld_issue_i  (ld_issue),
    .tag_i       (tag),
    .rdata_i     (rdata),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

// File: load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      ld_issue_i,
  input  ldst_pkg::ld_tag_t         tag_i,
  input  logic [ldst_pkg::XLEN-1:0] rdata_i,
  output logic                      rsp_valid_o,
  output ldst_pkg::ld_rsp_t         rsp_o
);

  import ldst_pkg::*;

  // Load whose memory read is in flight
  logic    ld_valid_q;
  ld_tag_t tag_q;

  // Extracted and extended data
  logic [XLEN-1:0] sel_data;

  // ----------------------------
  // In-flight tracking
  // ----------------------------
  // Valid bit, set in step with the memory read
  always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
    if (!arst_n_i) begin
      ld_valid_q <= 1'b0;
    end else begin
      ld_valid_q <= ld_issue_i;
    end
  end

  // Tag kept only for loads
  always_ff @(posedge clk_i) begin : tag_reg
    if (ld_issue_i) begin
      tag_q <= tag_i;
    end
  end

  // ----------------------------
  // Response forming
  // ----------------------------
  byte_selector i_byte_selector (
    .type_i     (tag_q.width),
    .byte_off_i (tag_q.offset),
    .data_i     (rdata_i),
    .data_o     (sel_data)
  );

  // Response follows the read data in the same cycle
  assign rsp_valid_o = ld_valid_q;
  assign rsp_o.data  = sel_data;

endmodule

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int unsigned ADDR_W = 8
) (
  input  logic                      clk_i,
  input  logic                      cmd_valid_i,
  input  ldst_pkg::ram_cmd_t        cmd_i,
  output logic [ldst_pkg::XLEN-1:0] rdata_o
);

  import ldst_pkg::*;

  // Doubleword index width and array depth
  localparam int unsigned IDX_W = ADDR_W - OFF_W;
  localparam int unsigned DEPTH = 2 ** IDX_W;

  // Storage, contents undefined until written
  logic [XLEN-1:0] mem [DEPTH];

  // Only the low index bits address this array
  logic [IDX_W-1:0] idx;

  assign idx = cmd_i.word_idx[IDX_W-1:0];

  // ----------------------------
  // Write port
  // ----------------------------
  // Per-lane write under the byte enables
  always_ff @(posedge clk_i) begin : ram_write
    if (cmd_valid_i && cmd_i.we) begin
      for (int unsigned l = 0; l < NUM_LANES; l++) begin
        if (cmd_i.be[l]) begin
          mem[idx][l*BYTE_LEN +: BYTE_LEN] <= cmd_i.wdata[l*BYTE_LEN +: BYTE_LEN];
        end
      end
    end
  end

  // ----------------------------
  // Read port
  // ----------------------------
  // Registered read for loads, data holds otherwise
  always_ff @(posedge clk_i) begin : ram_read
    if (cmd_valid_i && !cmd_i.we) begin
      rdata_o <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: ldst_issue.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_issue #(
  parameter int unsigned ADDR_W = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_valid_i,
  input  ldst_pkg::ldst_req_t req_i,
  output logic                cmd_valid_o,
  output ldst_pkg::ram_cmd_t  cmd_o,
  output logic                ld_issue_o,
  output ldst_pkg::ld_tag_t   tag_o,
  output logic                misalign_o
);

  import ldst_pkg::*;

  // Offset and size decode
  logic [OFF_W-1:0]     req_off;
  logic [OFF_W-1:0]     align_mask;
  logic [NUM_LANES-1:0] size_be;
  logic                 misaligned;

  // Next state of the registered outputs
  logic     cmd_valid_d;
  logic     ld_issue_d;
  logic     misalign_d;
  ram_cmd_t cmd_d;
  ld_tag_t  tag_d;

  assign req_off = req_i.addr[OFF_W-1:0];

  // ----------------------------
  // Size and alignment decode
  // ----------------------------
  // Mask of offset bits that must be zero, plus lane mask at offset 0
  always_comb begin : size_decode
    case (req_i.width)
      LS_BYTE, LS_BYTE_U: begin
        align_mask = 3'b000;
        size_be    = 8'h01;
      end
      LS_HALFWORD, LS_HALFWORD_U: begin
        align_mask = 3'b001;
        size_be    = 8'h03;
      end
      LS_WORD, LS_WORD_U: begin
        align_mask = 3'b011;
        size_be    = 8'h0f;
      end
      default: begin
        // Doubleword
        align_mask = 3'b111;
        size_be    = 8'hff;
      end
    endcase
  end

  // Any set offset bit under the mask breaks natural alignment
  assign misaligned = |(req_off & align_mask);

  // ----------------------------
  // Command and tag build
  // ----------------------------
  always_comb begin : cmd_build
    cmd_d.we       = req_i.is_store;
    cmd_d.word_idx = WORD_IDX_W'(req_i.addr[ADDR_W-1:OFF_W]);
    // Lanes start at the byte offset
    cmd_d.be       = size_be << req_off;
    // Store value moved up by offset times 8 bits
    cmd_d.wdata    = req_i.wdata << (req_off * BYTE_LEN);

    // Width and offset ride along with the load
    tag_d.width    = req_i.width;
    tag_d.offset   = req_off;
  end

  // Misaligned requests never reach memory
  assign cmd_valid_d = req_valid_i & ~misaligned;
  assign ld_issue_d  = cmd_valid_d & ~req_i.is_store;
  assign misalign_d  = req_valid_i & misaligned;

  // ----------------------------
  // Output registers
  // ----------------------------
  // Control strobes, one cycle after the request
  always_ff @(posedge clk_i or negedge arst_n_i) begin : ctrl_regs
    if (!arst_n_i) begin
      cmd_valid_o <= 1'b0;
      ld_issue_o  <= 1'b0;
      misalign_o  <= 1'b0;
    end else begin
      cmd_valid_o <= cmd_valid_d;
      ld_issue_o  <= ld_issue_d;
      misalign_o  <= misalign_d;
    end
  end

  // Payload, qualified by the strobes above
  always_ff @(posedge clk_i) begin : payload_regs
    cmd_o <= cmd_d;
    tag_o <= tag_d;
  end

endmodule

`default_nettype wire

// File: byte_selector.sv
`timescale 1ns/1ps
`default_nettype none

module byte_selector (
  input  ldst_pkg::ldst_width_t         type_i,      // Access width and signedness
  input  logic [ldst_pkg::OFF_W-1:0]    byte_off_i,  // Offset of the first byte
  input  logic [ldst_pkg::XLEN-1:0]     data_i,      // Full doubleword from memory
  output logic [ldst_pkg::XLEN-1:0]     data_o       // Extended load value
);

  import ldst_pkg::*;

  // Portions picked at each multiplexer level
  logic [4*BYTE_LEN-1:0] sel_word;
  logic [2*BYTE_LEN-1:0] sel_half;
  logic [BYTE_LEN-1:0]   sel_byte;

  // ----------------------------
  // Lane selection
  // ----------------------------
  // One multiplexer level per offset bit, widest first
  always_comb begin : lane_select
    // Offset bit 2 picks upper or lower word
    if (byte_off_i[2]) begin
      sel_word = data_i[8*BYTE_LEN-1 -: 4*BYTE_LEN];
    end else begin
      sel_word = data_i[4*BYTE_LEN-1 -: 4*BYTE_LEN];
    end
    // Offset bit 1 picks halfword within that word
    if (byte_off_i[1]) begin
      sel_half = sel_word[4*BYTE_LEN-1 -: 2*BYTE_LEN];
    end else begin
      sel_half = sel_word[2*BYTE_LEN-1 -: 2*BYTE_LEN];
    end
    // Offset bit 0 picks byte within that halfword
    if (byte_off_i[0]) begin
      sel_byte = sel_half[2*BYTE_LEN-1 -: BYTE_LEN];
    end else begin
      sel_byte = sel_half[BYTE_LEN-1 -: BYTE_LEN];
    end
  end

  // ----------------------------
  // Extension to XLEN
  // ----------------------------
  always_comb begin : extend
    case (type_i)
      // Byte loads
      LS_BYTE:       data_o = {{(XLEN - BYTE_LEN){sel_byte[BYTE_LEN-1]}}, sel_byte};
      LS_BYTE_U:     data_o = {{(XLEN - BYTE_LEN){1'b0}}, sel_byte};
      // Halfword loads
      LS_HALFWORD:   data_o = {{(XLEN - 2*BYTE_LEN){sel_half[2*BYTE_LEN-1]}}, sel_half};
      LS_HALFWORD_U: data_o = {{(XLEN - 2*BYTE_LEN){1'b0}}, sel_half};
      // Word loads
      LS_WORD:       data_o = {{(XLEN - 4*BYTE_LEN){sel_word[4*BYTE_LEN-1]}}, sel_word};
      LS_WORD_U:     data_o = {{(XLEN - 4*BYTE_LEN){1'b0}}, sel_word};
      // Doubleword goes through untouched
      LS_DOUBLEWORD: data_o = data_i;
      default:       data_o = data_i;
    endcase
  end

endmodule

`default_nettype wire

// File: ldst_pkg.sv
`default_nettype none

package ldst_pkg;

  // ----------------------------
  // Data path widths
  // ----------------------------
  // Fixed at 64 bits, eight byte lanes
  localparam int unsigned XLEN      = 64;
  localparam int unsigned BYTE_LEN  = 8;
  // Byte offset inside a doubleword
  localparam int unsigned OFF_W     = 3;
  // Lane count, one byte enable per lane
  localparam int unsigned NUM_LANES = XLEN / BYTE_LEN;

  // Request address field, top level only decodes ADDR_W of it
  localparam int unsigned REQ_ADDR_W = 16;
  // Doubleword index field toward the memory
  localparam int unsigned WORD_IDX_W = REQ_ADDR_W - OFF_W;

  // ----------------------------
  // Access width encoding
  // ----------------------------
  typedef enum logic [2:0] {
    LS_BYTE,
    LS_BYTE_U,
    LS_HALFWORD,
    LS_HALFWORD_U,
    LS_WORD,
    LS_WORD_U,
    LS_DOUBLEWORD
  } ldst_width_t;

  // ----------------------------
  // Interface structs
  // ----------------------------
  // Load or store request from the core
  typedef struct packed {
    logic                  is_store;
    ldst_width_t           width;
    logic [REQ_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;   // LSB aligned store value
  } ldst_req_t;

  // Memory command, store data already on its lanes
  typedef struct packed {
    logic                  we;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [NUM_LANES-1:0]  be;
    logic [XLEN-1:0]       wdata;
  } ram_cmd_t;

  // Load info kept while the read is in flight
  typedef struct packed {
    ldst_width_t      width;
    logic [OFF_W-1:0] offset;
  } ld_tag_t;

  // Load result, extended to XLEN
  typedef struct packed {
    logic [XLEN-1:0] data;
  } ld_rsp_t;

endpackage

`default_nettype wire
